// ==== Makefile ====
TOP = raster_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)

// ==== common/raster_cfg.svh ====
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// pixel coordinates are signed integers
`define RASTER_XW 16
`define RASTER_YW 16

// vertex attribute in signed fixed point
`define RASTER_VW 16
`define RASTER_VFRAC 14

// inverse of twice the signed area, supplied by software
`define RASTER_AINVW 16
`define RASTER_AINVFRAC 14

`define RASTER_FRAC 14 // fraction bits of a barycentric coefficient
`define RASTER_COEFW (2 + `RASTER_XW + (`RASTER_YW + 1) - `RASTER_FRAC)

`define RASTER_AXI_AW 6
`define RASTER_AXI_DW 32

// register byte offsets
`define RASTER_REG_CTRL 6'h00
`define RASTER_REG_VTX0 6'h04
`define RASTER_REG_VTX1 6'h08
`define RASTER_REG_VTX2 6'h0C
`define RASTER_REG_VAL0 6'h10
`define RASTER_REG_VAL1 6'h14
`define RASTER_REG_VAL2 6'h18
`define RASTER_REG_AINV 6'h1C
`define RASTER_REG_COUNT 6'h20

`endif

// ==== common/raster_pkg.sv ====
`include "raster_cfg.svh"

package raster_pkg;

  typedef logic signed [`RASTER_XW-1:0] coord_x_t;
  typedef logic signed [`RASTER_YW-1:0] coord_y_t;
  typedef logic signed [`RASTER_VW-1:0] val_t;
  typedef logic signed [`RASTER_AINVW-1:0] iarea_t;
  typedef logic signed [`RASTER_COEFW-1:0] coef_t;

  // y sits in the upper half so a vertex matches the register word layout
  typedef struct packed {
    coord_y_t y;
    coord_x_t x;
  } vertex_t;

  typedef struct packed {
    vertex_t [2:0] vtx;
    val_t [2:0] val;
    iarea_t iarea;
  } tri_t;

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    logic last; // final pixel of the bounding box
  } pixel_t;

  typedef struct packed {
    logic [`RASTER_AXI_DW-2:0] reserved;
    logic start;
  } ctrl_word_t;

  // one write data word seen either as a vertex or as the control word
  typedef union packed {
    vertex_t vtx;
    ctrl_word_t ctrl;
  } reg_word_u;

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    val_t value;
  } frag_t;

  typedef struct packed {
    logic awvalid;
    logic [`RASTER_AXI_AW-1:0] awaddr;
    logic wvalid;
    logic [`RASTER_AXI_DW-1:0] wdata;
    logic [`RASTER_AXI_DW/8-1:0] wstrb;
    logic bready;
    logic arvalid;
    logic [`RASTER_AXI_AW-1:0] araddr;
    logic rready;
  } axil_req_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
    logic [1:0] bresp;
    logic arready;
    logic rvalid;
    logic [`RASTER_AXI_DW-1:0] rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

endpackage

// ==== design/fragment_writer.sv ====
`timescale 1ns/10ps

module fragment_writer
  import raster_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_n,
  input  val_t        value,
  input  logic        in_tri,
  input  pixel_t      pixel,
  input  logic        pixel_valid,
  input  logic        start,
  output frag_t       frag,
  output logic        frag_valid,
  output logic        frame_done,
  output logic [31:0] frag_count
);
  logic keep;

  assign keep = pixel_valid && in_tri; // outside pixels never become fragments

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      frag_valid <= 1'b0;
      frame_done <= 1'b0;
      frag_count <= '0;
    end else begin
      frag_valid <= keep;
      frame_done <= pixel_valid && pixel.last;
      if (start) begin
        frag_count <= '0;
      end else if (keep) begin
        frag_count <= frag_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (keep) begin
      frag.x <= pixel.x;
      frag.y <= pixel.y;
      frag.value <= value;
    end
  end

endmodule

// ==== design/interp/barycentric_coeffs.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module barycentric_coeffs
  import raster_pkg::*;
(
  input  logic            clk_in,
  input  logic            rst_n,
  input  iarea_t          iarea,
  input  coord_x_t        x,
  input  coord_y_t        y,
  input  tri_t            triangle,
  output coef_t [2:0]     coeffs,
  output logic            in_tri
);
  localparam int DXW = `RASTER_XW + 1;
  localparam int DYW = `RASTER_YW + 1;
  localparam int PW = DXW + DYW;
  localparam int EW = PW + 1;
  localparam int SW = EW + `RASTER_AINVW;
  localparam int SHIFT = `RASTER_AINVFRAC - `RASTER_FRAC; // rebase onto coefficient fraction

  logic signed [DXW-1:0] dx [3];
  logic signed [DYW-1:0] dy [3];
  logic signed [PW-1:0] pa [3];
  logic signed [PW-1:0] pb [3];
  logic signed [EW-1:0] edge_q [3];
  logic signed [SW-1:0] scaled [3];

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < 3; i++) begin
      dx[i] <= $signed(triangle.vtx[i].x) - x; // vertex relative to the pixel
      dy[i] <= $signed(triangle.vtx[i].y) - y;
    end
  end

  // edge i is built from the two vertices opposite vertex i
  always_ff @(posedge clk_in) begin
    for (int i = 0; i < 3; i++) begin
      pa[i] <= dx[(i + 1) % 3] * dy[(i + 2) % 3];
      pb[i] <= dy[(i + 1) % 3] * dx[(i + 2) % 3];
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < 3; i++) begin
      edge_q[i] <= pa[i] - pb[i];
    end
  end

  // iarea is held by the register file for the whole frame
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      scaled[i] = edge_q[i] * iarea;
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < 3; i++) begin
      coeffs[i] <= scaled[i][SHIFT +: `RASTER_COEFW];
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      in_tri <= 1'b0;
    end else begin
      // all edges zero only happens for a degenerate triangle, which covers nothing
      in_tri <= !edge_q[0][EW-1] && !edge_q[1][EW-1] && !edge_q[2][EW-1] &&
                ((edge_q[0] | edge_q[1] | edge_q[2]) != '0);
    end
  end

endmodule

// ==== design/interp/barycentric_interpolator.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module barycentric_interpolator
  import raster_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_n,
  input  tri_t   triangle,
  input  pixel_t pixel,
  input  logic   pixel_valid,
  output val_t   value,
  output logic   in_tri,
  output pixel_t pixel_out,
  output logic   pixel_valid_out
);
  localparam int VW = `RASTER_VW;
  localparam int PRODW = VW + `RASTER_COEFW;
  localparam int SUMW = PRODW + 2;
  localparam int PIXW = $bits(pixel_t);

  coef_t [2:0] coeffs;
  logic coef_in_tri;
  val_t [2:0] vals;
  val_t [2:0] a_q;
  coef_t [2:0] b_q;
  logic signed [PRODW-1:0] prod [3];
  logic signed [PRODW-1:0] prod_q [3];
  logic signed [SUMW-1:0] sum01;
  logic signed [SUMW-1:0] p2_q;
  logic signed [SUMW-1:0] sum_q;
  logic [PIXW:0] pix_d;

  barycentric_coeffs coeffs_inst (
    .clk_in(clk_in),
    .rst_n(rst_n),
    .iarea(triangle.iarea),
    .x(pixel.x),
    .y(pixel.y),
    .triangle(triangle),
    .coeffs(coeffs),
    .in_tri(coef_in_tri)
  );

  // values wait for the 4 coefficient stages
  pipeline #(.STAGES(4), .DATA_WIDTH(3 * VW)) vals_pipe (
    .clk_in(clk_in), .rst_n(rst_n), .data(triangle.val), .data_out(vals)
  );

  // operand, multiply and product registers followed by a two level adder
  always_ff @(posedge clk_in) begin
    a_q <= vals;
    b_q <= coeffs;
    for (int i = 0; i < 3; i++) begin
      prod[i] <= $signed(a_q[i]) * $signed(b_q[i]);
    end
    prod_q <= prod;
    sum01 <= prod_q[0] + prod_q[1];
    p2_q <= prod_q[2];
    sum_q <= sum01 + p2_q;
    value <= sum_q[`RASTER_FRAC +: VW]; // drop the coefficient fraction
  end

  pipeline #(.STAGES(6), .DATA_WIDTH(1)) flag_pipe (
    .clk_in(clk_in), .rst_n(rst_n), .data(coef_in_tri), .data_out(in_tri)
  );

  pipeline #(.STAGES(10), .DATA_WIDTH(PIXW + 1)) pixel_pipe (
    .clk_in(clk_in), .rst_n(rst_n), .data({pixel, pixel_valid}), .data_out(pix_d)
  );

  assign {pixel_out, pixel_valid_out} = pix_d;

endmodule

// ==== design/pipeline.sv ====
`timescale 1ns/10ps

module pipeline #(
  parameter int STAGES = 1,
  parameter int DATA_WIDTH = 1
) (
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] data,
  output logic [DATA_WIDTH-1:0] data_out
);
  logic [STAGES-1:0][DATA_WIDTH-1:0] shreg;

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      shreg <= '0;
    end else begin
      shreg[0] <= data;
      for (int i = 1; i < STAGES; i++) begin
        shreg[i] <= shreg[i-1];
      end
    end
  end

  assign data_out = shreg[STAGES-1]; // oldest entry

endmodule

// ==== design/pixel_scanner.sv ====
`timescale 1ns/10ps

module pixel_scanner
  import raster_pkg::*;
(
  input  logic   clk_in,
  input  logic   rst_n,
  input  tri_t   triangle,
  input  logic   start,
  output pixel_t pixel,
  output logic   pixel_valid
);
  coord_x_t x_lo;
  coord_x_t x_hi;
  coord_y_t y_lo;
  coord_y_t y_hi;
  coord_x_t x_min_q;
  coord_x_t x_max_q;
  coord_y_t y_max_q;

  // bounding box of the three vertices
  always_comb begin
    x_lo = $signed(triangle.vtx[0].x);
    x_hi = x_lo;
    y_lo = $signed(triangle.vtx[0].y);
    y_hi = y_lo;
    for (int i = 1; i < 3; i++) begin
      if ($signed(triangle.vtx[i].x) < x_lo) x_lo = triangle.vtx[i].x;
      if ($signed(triangle.vtx[i].x) > x_hi) x_hi = triangle.vtx[i].x;
      if ($signed(triangle.vtx[i].y) < y_lo) y_lo = triangle.vtx[i].y;
      if ($signed(triangle.vtx[i].y) > y_hi) y_hi = triangle.vtx[i].y;
    end
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      pixel_valid <= 1'b0;
    end else if (start) begin
      pixel_valid <= 1'b1;
    end else if (pixel_valid && pixel.last) begin
      pixel_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (start) begin
      x_min_q <= x_lo;
      x_max_q <= x_hi;
      y_max_q <= y_hi;
      pixel.x <= x_lo; // first pixel is the top left corner of the box
      pixel.y <= y_lo;
      pixel.last <= (x_lo == x_hi) && (y_lo == y_hi);
    end else if (pixel_valid && !pixel.last) begin
      if (pixel.x == x_max_q) begin
        // wrap to the start of the next row
        pixel.x <= x_min_q;
        pixel.y <= pixel.y + 1'b1;
        pixel.last <= (x_min_q == x_max_q) && (pixel.y + 1'b1 == y_max_q);
      end else begin
        pixel.x <= pixel.x + 1'b1;
        pixel.last <= (pixel.x + 1'b1 == x_max_q) && (pixel.y == y_max_q);
      end
    end
  end

endmodule

// ==== design/raster_shader_top.sv ====
`timescale 1ns/10ps

module raster_shader_top
  import raster_pkg::*;
(
  input  logic      clk_in,
  input  logic      rst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output frag_t     frag,
  output logic      frag_valid
);
  tri_t triangle;
  logic start;
  logic frame_done;
  logic [31:0] frag_count;
  pixel_t pixel;
  logic pixel_valid;
  val_t value;
  logic in_tri;
  pixel_t pixel_d;
  logic pixel_valid_d;

  tri_setup tri_setup_inst (
    .clk_in(clk_in), .rst_n(rst_n),
    .axil_req(axil_req), .axil_rsp(axil_rsp),
    .triangle(triangle), .start(start),
    .frame_done(frame_done), .frag_count(frag_count)
  );

  pixel_scanner pixel_scanner_inst (
    .clk_in(clk_in), .rst_n(rst_n), .triangle(triangle), .start(start),
    .pixel(pixel), .pixel_valid(pixel_valid)
  );

  // ten cycles from pixel to interpolated value
  barycentric_interpolator interp_inst (
    .clk_in(clk_in), .rst_n(rst_n), .triangle(triangle),
    .pixel(pixel), .pixel_valid(pixel_valid),
    .value(value), .in_tri(in_tri),
    .pixel_out(pixel_d), .pixel_valid_out(pixel_valid_d)
  );

  fragment_writer fragment_writer_inst (
    .clk_in(clk_in), .rst_n(rst_n), .value(value), .in_tri(in_tri),
    .pixel(pixel_d), .pixel_valid(pixel_valid_d), .start(start),
    .frag(frag), .frag_valid(frag_valid),
    .frame_done(frame_done), .frag_count(frag_count)
  );

endmodule

// ==== design/tri_setup/tri_setup.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module tri_setup
  import raster_pkg::*;
(
  input  logic        clk_in,
  input  logic        rst_n,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  output tri_t        triangle,
  output logic        start,
  input  logic        frame_done,
  input  logic [31:0] frag_count
);
  localparam int DW = `RASTER_AXI_DW;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  reg_word_u wword;
  logic wr_fire;
  logic rd_fire;
  logic ctrl_hit;
  logic geom_hit;
  logic wr_err;
  logic start_go;
  logic busy;
  logic done;
  logic bvalid_q;
  logic [1:0] bresp_q;
  logic rvalid_q;
  logic [DW-1:0] rdata_q;
  tri_t triangle_q;

  assign wword = axil_req.wdata;

  // address and data are taken together, one write in flight at a time
  assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
  assign rd_fire = axil_req.arvalid && !rvalid_q;

  assign ctrl_hit = (axil_req.awaddr == `RASTER_REG_CTRL);
  assign geom_hit = (axil_req.awaddr >= `RASTER_REG_VTX0) &&
                    (axil_req.awaddr <= `RASTER_REG_AINV);
  assign wr_err = busy && (ctrl_hit || geom_hit); // the running frame owns the geometry
  assign start_go = wr_fire && ctrl_hit && wword.ctrl.start && !busy;

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready = wr_fire;
    axil_rsp.bvalid = bvalid_q;
    axil_rsp.bresp = bresp_q;
    axil_rsp.arready = rd_fire;
    axil_rsp.rvalid = rvalid_q;
    axil_rsp.rdata = rdata_q;
    axil_rsp.rresp = RESP_OKAY; // every read is legal, unmapped ones just return zero
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
      bresp_q <= RESP_OKAY;
      rvalid_q <= 1'b0;
      start <= 1'b0;
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      start <= start_go; // single cycle pulse to the scanner

      if (wr_fire) begin
        bvalid_q <= 1'b1;
        bresp_q <= wr_err ? RESP_SLVERR : RESP_OKAY;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end

      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end

      // busy covers the frame from start until the last fragment has left
      if (start_go) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (frame_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_fire && !busy) begin
      case (axil_req.awaddr)
        `RASTER_REG_VTX0: triangle_q.vtx[0] <= wword.vtx;
        `RASTER_REG_VTX1: triangle_q.vtx[1] <= wword.vtx;
        `RASTER_REG_VTX2: triangle_q.vtx[2] <= wword.vtx;
        `RASTER_REG_VAL0: triangle_q.val[0] <= axil_req.wdata[`RASTER_VW-1:0];
        `RASTER_REG_VAL1: triangle_q.val[1] <= axil_req.wdata[`RASTER_VW-1:0];
        `RASTER_REG_VAL2: triangle_q.val[2] <= axil_req.wdata[`RASTER_VW-1:0];
        `RASTER_REG_AINV: triangle_q.iarea <= axil_req.wdata[`RASTER_AINVW-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (rd_fire) begin
      case (axil_req.araddr)
        `RASTER_REG_CTRL: rdata_q <= {{(DW-3){1'b0}}, done, busy, 1'b0};
        `RASTER_REG_VTX0: rdata_q <= triangle_q.vtx[0];
        `RASTER_REG_VTX1: rdata_q <= triangle_q.vtx[1];
        `RASTER_REG_VTX2: rdata_q <= triangle_q.vtx[2];
        `RASTER_REG_VAL0: rdata_q <= DW'($signed(triangle_q.val[0]));
        `RASTER_REG_VAL1: rdata_q <= DW'($signed(triangle_q.val[1]));
        `RASTER_REG_VAL2: rdata_q <= DW'($signed(triangle_q.val[2]));
        `RASTER_REG_AINV: rdata_q <= DW'($signed(triangle_q.iarea));
        `RASTER_REG_COUNT: rdata_q <= frag_count;
        default: rdata_q <= '0;
      endcase
    end
  end

  assign triangle = triangle_q;

endmodule

// ==== tb.f ====
+incdir+common
common/raster_pkg.sv
design/pipeline.sv
design/tri_setup/tri_setup.sv
design/pixel_scanner.sv
design/interp/barycentric_coeffs.sv
design/interp/barycentric_interpolator.sv
design/fragment_writer.sv
design/raster_shader_top.sv
test/raster_tb_assert.sv
test/raster_tb.sv

// ==== test/raster_tb.sv ====
`timescale 1ns/10ps
`include "raster_cfg.svh"

module raster_tb
  import raster_pkg::*;
();
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam int HANDSHAKE_TIMEOUT = 32;
  localparam int DONE_POLLS = 400;
  localparam int RANDOM_TRIANGLES = 12;

  typedef logic [`RASTER_AXI_AW-1:0] addr_t;

  logic clk_in;
  logic rst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  frag_t frag;
  logic frag_valid;
  frag_t exp_q[$]; // fragments still owed by the DUT, in raster order
  frag_t want_frag;

  raster_shader_top raster_shader_top_inst (
    .clk_in(clk_in), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
    .frag(frag), .frag_valid(frag_valid)
  );

  always #10 clk_in = ~clk_in;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_frag(input frag_t got, input frag_t want);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: fragment (%0d,%0d) %0d, want (%0d,%0d) %0d",
                          $time, got.x, got.y, got.value, want.x, want.y, want.value));
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: %s read %h, want %h", $time, what, got, want));
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] want, input string what);
    if (got !== want) begin
      abort_run($sformatf("mismatch at %0t: %s response %b, want %b", $time, what, got, want));
    end
  endtask

  function automatic longint twice_area(input tri_t t);
    return (longint'(t.vtx[1].x) - longint'(t.vtx[0].x)) *
           (longint'(t.vtx[2].y) - longint'(t.vtx[0].y)) -
           (longint'(t.vtx[1].y) - longint'(t.vtx[0].y)) *
           (longint'(t.vtx[2].x) - longint'(t.vtx[0].x));
  endfunction

  // coverage and attribute of one pixel, computed in plain integer arithmetic
  function automatic logic interp_ref(input tri_t t, input longint px, input longint py,
                                      output val_t value);
    longint e [3];
    longint sum;
    int a;
    int b;
    sum = 0;
    for (int i = 0; i < 3; i++) begin
      a = (i + 1) % 3;
      b = (i + 2) % 3;
      e[i] = (longint'(t.vtx[a].x) - px) * (longint'(t.vtx[b].y) - py) -
             (longint'(t.vtx[a].y) - py) * (longint'(t.vtx[b].x) - px);
      sum += longint'(t.val[i]) * e[i] * longint'(t.iarea); // coefficient carries FRAC bits
    end
    value = val_t'(sum >>> `RASTER_FRAC);
    // only a counter-clockwise triangle with nonzero area covers anything
    return (e[0] + e[1] + e[2] > 0) && e[0] >= 0 && e[1] >= 0 && e[2] >= 0;
  endfunction

  function automatic tri_t make_triangle(input int x0, input int y0, input int x1,
                                         input int y1, input int x2, input int y2);
    tri_t t;
    longint area2;
    t.vtx[0].x = coord_x_t'(x0);
    t.vtx[0].y = coord_y_t'(y0);
    t.vtx[1].x = coord_x_t'(x1);
    t.vtx[1].y = coord_y_t'(y1);
    t.vtx[2].x = coord_x_t'(x2);
    t.vtx[2].y = coord_y_t'(y2);
    for (int i = 0; i < 3; i++) begin
      t.val[i] = val_t'(int'($urandom_range(32767)) - 16384); // stays within +-1.0
    end
    area2 = twice_area(t);
    t.iarea = '0;
    if (area2 != 0) t.iarea = iarea_t'((longint'(1) <<< `RASTER_AINVFRAC) / area2);
    return t;
  endfunction

  function automatic tri_t random_triangle();
    int c [6];
    tri_t t;
    for (int k = 0; k < 4; k++) begin
      foreach (c[i]) c[i] = int'($urandom_range(15)) - 4;
      t = make_triangle(c[0], c[1], c[2], c[3], c[4], c[5]);
      if (twice_area(t) != 0) break; // a collinear pick that survives is still legal
    end
    // swapping two vertices turns a clockwise triangle around
    if (twice_area(t) < 0) t = make_triangle(c[0], c[1], c[4], c[5], c[2], c[3]);
    return t;
  endfunction

  task automatic axi_write(input addr_t addr, input logic [31:0] data, output logic [1:0] resp);
    int waited;
    int delay;
    @(negedge clk_in);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr = addr;
    axil_req.wvalid = 1'b1;
    axil_req.wdata = data;
    waited = 0;
    @(posedge clk_in);
    while (!(axil_rsp.awready && axil_rsp.wready)) begin // ready as seen just before the edge
      if (waited == HANDSHAKE_TIMEOUT) abort_run("timeout: write was never accepted");
      waited++;
      @(posedge clk_in);
    end
    @(negedge clk_in);
    if (!axil_rsp.bvalid) abort_run("no write response in the cycle after the write was taken");
    if (axil_rsp.awready || axil_rsp.wready) abort_run("write ready stayed high after the write");
    axil_req.awvalid = 1'b0;
    axil_req.wvalid = 1'b0;
    delay = $urandom_range(3);
    repeat (delay) @(negedge clk_in); // response has to wait for a slow master
    resp = axil_rsp.bresp;
    axil_req.bready = 1'b1;
    @(negedge clk_in);
    axil_req.bready = 1'b0;
    if (axil_rsp.bvalid) abort_run("bvalid stayed high after bready was given");
  endtask

  task automatic axi_read(input addr_t addr, output logic [31:0] data);
    int waited;
    int delay;
    @(negedge clk_in);
    axil_req.arvalid = 1'b1;
    axil_req.araddr = addr;
    waited = 0;
    @(posedge clk_in);
    while (!axil_rsp.arready) begin
      if (waited == HANDSHAKE_TIMEOUT) abort_run("timeout: read was never accepted");
      waited++;
      @(posedge clk_in);
    end
    @(negedge clk_in);
    if (!axil_rsp.rvalid) abort_run("no read data in the cycle after the read was taken");
    if (axil_rsp.arready) abort_run("arready stayed high after the read");
    axil_req.arvalid = 1'b0;
    delay = $urandom_range(3);
    repeat (delay) @(negedge clk_in);
    data = axil_rsp.rdata;
    check_resp(axil_rsp.rresp, RESP_OKAY, "read");
    axil_req.rready = 1'b1;
    @(negedge clk_in);
    axil_req.rready = 1'b0;
    if (axil_rsp.rvalid) abort_run("rvalid stayed high after rready was given");
  endtask

  task automatic program_triangle(input tri_t t);
    reg_word_u w;
    logic [1:0] resp;
    logic [31:0] rd;
    for (int i = 0; i < 3; i++) begin
      w = '0;
      w.vtx = t.vtx[i];
      axi_write(addr_t'(`RASTER_REG_VTX0 + 4 * i), w, resp);
      check_resp(resp, RESP_OKAY, "vertex write");
      axi_read(addr_t'(`RASTER_REG_VTX0 + 4 * i), rd);
      check_word(rd, w, "vertex readback");
      axi_write(addr_t'(`RASTER_REG_VAL0 + 4 * i), 32'(t.val[i]), resp);
      check_resp(resp, RESP_OKAY, "value write");
    end
    axi_write(`RASTER_REG_AINV, 32'(t.iarea), resp);
    check_resp(resp, RESP_OKAY, "inverse area write");
  endtask

  // walks the bounding box in raster order and queues every covered pixel
  task automatic expect_frame(input tri_t t, output int count);
    longint x_lo;
    longint x_hi;
    longint y_lo;
    longint y_hi;
    frag_t f;
    val_t v;
    x_lo = t.vtx[0].x;
    x_hi = x_lo;
    y_lo = t.vtx[0].y;
    y_hi = y_lo;
    for (int i = 1; i < 3; i++) begin
      if (t.vtx[i].x < x_lo) x_lo = t.vtx[i].x;
      if (t.vtx[i].x > x_hi) x_hi = t.vtx[i].x;
      if (t.vtx[i].y < y_lo) y_lo = t.vtx[i].y;
      if (t.vtx[i].y > y_hi) y_hi = t.vtx[i].y;
    end
    count = 0;
    for (longint y = y_lo; y <= y_hi; y++) begin
      for (longint x = x_lo; x <= x_hi; x++) begin
        if (interp_ref(t, x, y, v)) begin
          f.x = coord_x_t'(x);
          f.y = coord_y_t'(y);
          f.value = v;
          exp_q.push_back(f);
          count++;
        end
      end
    end
  endtask

  task automatic wait_frame_done();
    logic [31:0] ctrl;
    int polls;
    polls = 0;
    axi_read(`RASTER_REG_CTRL, ctrl);
    while (!ctrl[2]) begin
      if (polls == DONE_POLLS) abort_run("timeout: frame never reported done");
      polls++;
      axi_read(`RASTER_REG_CTRL, ctrl);
    end
  endtask

  task automatic run_frame(input tri_t t, input bit poke_busy);
    reg_word_u w;
    logic [1:0] resp;
    logic [31:0] rd;
    int n_exp;
    program_triangle(t);
    expect_frame(t, n_exp);
    w = '0;
    w.ctrl.start = 1'b1;
    axi_write(`RASTER_REG_CTRL, w, resp);
    check_resp(resp, RESP_OKAY, "start write");
    if (poke_busy) begin
      w = '0;
      w.vtx.x = 7;
      w.vtx.y = -3;
      axi_write(`RASTER_REG_VTX0, w, resp);
      check_resp(resp, RESP_SLVERR, "vertex write while busy");
      w = '0;
      w.ctrl.start = 1'b1;
      axi_write(`RASTER_REG_CTRL, w, resp);
      check_resp(resp, RESP_SLVERR, "start write while busy");
      axi_read(`RASTER_REG_CTRL, rd);
      check_word(rd, 32'h2, "control while busy");
    end
    wait_frame_done();
    if (exp_q.size() != 0) abort_run("frame ended before all expected fragments arrived");
    axi_read(`RASTER_REG_COUNT, rd);
    check_word(rd, 32'(n_exp), "fragment count");
    axi_read(`RASTER_REG_CTRL, rd);
    check_word(rd, 32'h4, "control after frame");
    if (poke_busy) begin
      axi_read(`RASTER_REG_VTX0, rd);
      check_word(rd, t.vtx[0], "vertex 0 after rejected write");
    end
  endtask

  always @(negedge clk_in) begin
    if (rst_n && frag_valid) begin
      if (exp_q.size() == 0) begin
        abort_run("a fragment appeared where none was expected");
      end else begin
        want_frag = exp_q.pop_front();
        check_frag(frag, want_frag);
      end
    end
  end

  initial begin
    logic [31:0] rd;
    void'($urandom(41));
    clk_in = 1'b0;
    rst_n = 1'b0;
    axil_req = '0;
    axil_req.wstrb = '1;
    repeat (16) @(negedge clk_in);
    rst_n = 1'b1;
    axi_read(`RASTER_REG_CTRL, rd);
    check_word(rd, 32'h0, "control after reset");
    axi_read(6'h24, rd);
    check_word(rd, 32'h0, "unmapped register");
    // the big box leaves time to poke registers mid frame
    run_frame(make_triangle(0, 0, 12, 0, 0, 12), 1'b1);
    run_frame(make_triangle(0, 0, 3, 3, 6, 6), 1'b0); // collinear
    run_frame(make_triangle(0, 0, 0, 5, 5, 0), 1'b0); // clockwise
    for (int n = 0; n < RANDOM_TRIANGLES; n++) begin
      run_frame(random_triangle(), 1'b0);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== test/raster_tb_assert.sv ====
`timescale 1ns/10ps

module raster_tb_assert
  import raster_pkg::*;
(
  input logic      clk_in,
  input logic      rst_n,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp,
  input logic      frag_valid,
  input logic      busy
);

  // a response stays on the bus unchanged until the master takes it
  b_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else $error("write response dropped or changed before bready");

  r_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("read response dropped or changed before rready");

  reset_quiet: assert property (@(posedge clk_in)
    !rst_n && $past(!rst_n) |-> !frag_valid) // the first reset edge clears the register
    else $error("fragment output active during reset");

  frag_in_frame: assert property (@(posedge clk_in) disable iff (!rst_n)
    $rose(frag_valid) |-> busy)
    else $error("fragment started outside a frame");

endmodule

bind raster_shader_top raster_tb_assert assert_inst (
  .clk_in(clk_in), .rst_n(rst_n), .axil_req(axil_req), .axil_rsp(axil_rsp),
  .frag_valid(frag_valid), .busy(tri_setup_inst.busy)
);
